//--- alu.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module alu (
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  input  rvPkg::aluOpT     aluOp,
  output logic [`XLEN-1:0] result,
  output logic             zero,      // a equals b
  output logic             lessThan   // Signed a below b
);

  localparam int ShamtW = $clog2(`XLEN);

  logic [`XLEN-1:0] diff;
  logic [ShamtW-1:0] shamt;

  assign diff  = a - b;               // Shared by sub and the compares
  assign shamt = b[ShamtW-1:0];       // Low bits only as in RV32I

  // Flags follow the operands, not the op, so branches see them directly
  assign zero     = (diff == '0);
  assign lessThan = ($signed(a) < $signed(b));

  always_comb begin
    unique case (aluOp)
      rvPkg::opAdd: result = a + b;
      rvPkg::opSub: result = diff;
      rvPkg::opAnd: result = a & b;
      rvPkg::opOr:  result = a | b;
      rvPkg::opXor: result = a ^ b;
      rvPkg::opSlt: result = {{(`XLEN-1){1'b0}}, lessThan};
      rvPkg::opSll: result = a << shamt;
      rvPkg::opSrl: result = a >> shamt;   // Logical shift
      default:      result = '0;
    endcase
  end

endmodule

//--- files.f
+incdir+.
rvPkg.sv
regFile.sv
alu.sv
stageE.sv
stageM.sv
hazardUnit.sv
rvExecuteCore.sv
tbMonitor.sv
tbCore.sv

//--- hazardUnit.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module hazardUnit (
  input  logic [`REG_ADDR_W-1:0] rs1D,
  input  logic [`REG_ADDR_W-1:0] rs2D,
  input  logic                   validD,
  input  logic [`REG_ADDR_W-1:0] rs1E,
  input  logic [`REG_ADDR_W-1:0] rs2E,
  input  logic [`REG_ADDR_W-1:0] rdE,
  input  rvPkg::resultSrcT       resultSrcE,
  input  logic                   regWriteE,
  input  logic [`REG_ADDR_W-1:0] rdM,
  input  logic                   regWriteM,
  input  logic [`REG_ADDR_W-1:0] rdW,
  input  logic                   regWriteW,
  input  logic                   pcSrcE,
  output rvPkg::fwdSelT          forwardAE,
  output rvPkg::fwdSelT          forwardBE,
  output logic                   stallD,
  output logic                   flushE
);

  logic loadE;
  logic useD;

  // Newest producer wins, x0 is never forwarded
  function automatic rvPkg::fwdSelT fwdFor(input logic [`REG_ADDR_W-1:0] rs);
    rvPkg::fwdSelT sel;
    if (regWriteM && (rdM != '0) && (rdM == rs)) begin
      sel = rvPkg::fwdM;
    end else if (regWriteW && (rdW != '0) && (rdW == rs)) begin
      sel = rvPkg::fwdW;
    end else begin
      sel = rvPkg::fwdRf;
    end
    return sel;
  endfunction

  always_comb begin
    forwardAE = fwdFor(rs1E);
    forwardBE = fwdFor(rs2E);
  end

  assign loadE  = regWriteE & (resultSrcE == rvPkg::srcMem) & (rdE != '0);
  assign useD   = validD & ((rs1D == rdE) | (rs2D == rdE));
  assign stallD = loadE & useD;        // Clears itself once the load leaves E
  assign flushE = stallD | pcSrcE;     // Bubble on stall, squash on redirect

endmodule

//--- pipe_config.svh
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// Datapath and address width
`define XLEN 32

// Register index width, 32 architectural registers
`define REG_ADDR_W 5

// Data memory size in 32-bit words
`define DMEM_WORDS 64

`endif

//--- regFile.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module regFile (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic [`REG_ADDR_W-1:0] rs1,        // Read index A
  input  logic [`REG_ADDR_W-1:0] rs2,        // Read index B
  output logic [`XLEN-1:0]       rd1,
  output logic [`XLEN-1:0]       rd2,
  input  logic [`REG_ADDR_W-1:0] rdW,        // Write index
  input  logic                   regWriteW,
  input  logic [`XLEN-1:0]       resultW
);

  localparam int NumRegs = 1 << `REG_ADDR_W;

  logic [`XLEN-1:0] regs [NumRegs];

  // Read with x0 forced to zero and same-cycle write bypass
  function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] idx);
    logic [`XLEN-1:0] val;
    if (idx == '0) begin
      val = '0;                                // x0 always reads zero
    end else if (regWriteW && (rdW == idx)) begin
      val = resultW;                           // Write-through
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (regWriteW && (rdW != '0)) begin  // Writes to x0 dropped
      regs[rdW] <= resultW;
    end
  end

  always_comb begin
    rd1 = readPort(rs1);
    rd2 = readPort(rs2);
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and fail if the log reports a failure

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary -Wno-fatal --top-module tbCore -f files.f -o simTb > build.log 2>&1 \
  && ./obj_dir/simTb > sim.log 2>&1 \
  || { cat build.log; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0

//--- rvExecuteCore.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module rvExecuteCore (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   validD,
  input  logic [`REG_ADDR_W-1:0] rs1D,
  input  logic [`REG_ADDR_W-1:0] rs2D,
  input  logic [`REG_ADDR_W-1:0] rdD,
  input  logic [`XLEN-1:0]       immExtD,
  input  logic [`XLEN-1:0]       pcD,
  input  rvPkg::aluOpT           aluOpD,
  input  logic                   aluSrcD,
  input  logic                   regWriteD,
  input  logic                   memWriteD,
  input  rvPkg::resultSrcT       resultSrcD,
  input  logic                   branchD,
  input  rvPkg::brCondT          brCondD,
  input  logic                   jumpD,
  output logic                   stallD,     // Hold decode inputs
  output logic                   pcSrcE,     // Redirect strobe
  output logic [`XLEN-1:0]       pcTargetE,
  output logic                   regWriteW,
  output logic [`REG_ADDR_W-1:0] rdW,
  output logic [`XLEN-1:0]       resultW
);

  logic [`XLEN-1:0]       rd1D;
  logic [`XLEN-1:0]       rd2D;
  logic [`REG_ADDR_W-1:0] rs1E;
  logic [`REG_ADDR_W-1:0] rs2E;
  logic [`REG_ADDR_W-1:0] rdE;
  logic                   regWriteE;
  logic                   memWriteE;
  rvPkg::resultSrcT       resultSrcE;
  logic [`XLEN-1:0]       aluResultE;
  logic [`XLEN-1:0]       writeDataE;
  logic [`XLEN-1:0]       pcPlus4E;
  logic [`XLEN-1:0]       aluResultM;
  logic [`REG_ADDR_W-1:0] rdM;
  logic                   regWriteM;
  rvPkg::fwdSelT          forwardAE;
  rvPkg::fwdSelT          forwardBE;
  logic                   flushE;

  regFile regFile0 (
    .clk, .arstN,
    .rs1 (rs1D), .rs2 (rs2D),
    .rd1 (rd1D), .rd2 (rd2D),
    .rdW, .regWriteW, .resultW
  );

  stageE stageE0 (
    .clk, .arstN, .flushE,
    .validD, .rs1D, .rs2D, .rdD, .immExtD, .pcD,
    .aluOpD, .aluSrcD, .regWriteD, .memWriteD, .resultSrcD,
    .branchD, .brCondD, .jumpD, .rd1D, .rd2D,
    .aluResultM, .resultW, .forwardAE, .forwardBE,
    .rs1E, .rs2E, .rdE, .regWriteE, .memWriteE, .resultSrcE,
    .aluResultE, .writeDataE, .pcPlus4E, .pcSrcE, .pcTargetE
  );

  stageM stageM0 (
    .clk, .arstN,
    .aluResultE, .writeDataE, .rdE, .regWriteE, .resultSrcE,
    .memWriteE, .pcPlus4E,
    .aluResultM, .rdM, .regWriteM,
    .resultSrcM (),                  // Only used inside the stage
    .resultW, .rdW, .regWriteW
  );

  hazardUnit hazardUnit0 (
    .rs1D, .rs2D, .validD,
    .rs1E, .rs2E, .rdE, .resultSrcE, .regWriteE,
    .rdM, .regWriteM, .rdW, .regWriteW, .pcSrcE,
    .forwardAE, .forwardBE, .stallD, .flushE
  );

endmodule

//--- rvPkg.sv
package rvPkg;

  // ALU operation select
  typedef enum logic [2:0] {
    opAdd = 3'd0,
    opSub = 3'd1,
    opAnd = 3'd2,
    opOr  = 3'd3,
    opXor = 3'd4,
    opSlt = 3'd5,
    opSll = 3'd6,
    opSrl = 3'd7
  } aluOpT;

  // Writeback source
  typedef enum logic [1:0] {
    srcAlu = 2'd0,  // ALU result
    srcMem = 2'd1,  // Load data
    srcPc4 = 2'd2   // Link address for jumps
  } resultSrcT;

  // Operand forwarding select
  typedef enum logic [1:0] {
    fwdRf = 2'd0,   // Value read in decode
    fwdW  = 2'd1,   // Writeback result
    fwdM  = 2'd2    // Memory-stage ALU result
  } fwdSelT;

  // Branch condition
  typedef enum logic [1:0] {
    brEq = 2'd0,
    brNe = 2'd1,
    brLt = 2'd2,
    brGe = 2'd3
  } brCondT;

endpackage

//--- stageE.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module stageE (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   flushE,      // Load a bubble
  input  logic                   validD,
  input  logic [`REG_ADDR_W-1:0] rs1D,
  input  logic [`REG_ADDR_W-1:0] rs2D,
  input  logic [`REG_ADDR_W-1:0] rdD,
  input  logic [`XLEN-1:0]       immExtD,
  input  logic [`XLEN-1:0]       pcD,
  input  rvPkg::aluOpT           aluOpD,
  input  logic                   aluSrcD,     // Immediate as operand B
  input  logic                   regWriteD,
  input  logic                   memWriteD,
  input  rvPkg::resultSrcT       resultSrcD,
  input  logic                   branchD,
  input  rvPkg::brCondT          brCondD,
  input  logic                   jumpD,
  input  logic [`XLEN-1:0]       rd1D,
  input  logic [`XLEN-1:0]       rd2D,
  input  logic [`XLEN-1:0]       aluResultM,  // Forward sources
  input  logic [`XLEN-1:0]       resultW,
  input  rvPkg::fwdSelT          forwardAE,
  input  rvPkg::fwdSelT          forwardBE,
  output logic [`REG_ADDR_W-1:0] rs1E,
  output logic [`REG_ADDR_W-1:0] rs2E,
  output logic [`REG_ADDR_W-1:0] rdE,
  output logic                   regWriteE,
  output logic                   memWriteE,
  output rvPkg::resultSrcT       resultSrcE,
  output logic [`XLEN-1:0]       aluResultE,
  output logic [`XLEN-1:0]       writeDataE,
  output logic [`XLEN-1:0]       pcPlus4E,
  output logic                   pcSrcE,      // Taken branch or jump
  output logic [`XLEN-1:0]       pcTargetE
);

  logic [`XLEN-1:0] rd1E;
  logic [`XLEN-1:0] rd2E;
  logic [`XLEN-1:0] immExtE;
  logic [`XLEN-1:0] pcE;
  rvPkg::aluOpT     aluOpE;
  logic             aluSrcE;
  logic             branchE;
  rvPkg::brCondT    brCondE;
  logic             jumpE;
  logic             bubbleD;
  logic [`XLEN-1:0] srcAE;
  logic [`XLEN-1:0] srcBE;
  logic             zeroE;
  logic             lessE;
  logic             condMetE;

  // Three-way operand select, same for both sources
  function automatic logic [`XLEN-1:0] fwdMux(input rvPkg::fwdSelT sel,
                                               input logic [`XLEN-1:0] rfVal);
    logic [`XLEN-1:0] val;
    unique case (sel)
      rvPkg::fwdW: val = resultW;
      rvPkg::fwdM: val = aluResultM;
      default:     val = rfVal;
    endcase
    return val;
  endfunction

  assign bubbleD = flushE | ~validD;   // Empty slot or squash

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regWriteE  <= 1'b0;
      memWriteE  <= 1'b0;
      branchE    <= 1'b0;
      jumpE      <= 1'b0;
      resultSrcE <= rvPkg::srcAlu;
      rd1E       <= '0;
      rd2E       <= '0;
      immExtE    <= '0;
      pcE        <= '0;
      rs1E       <= '0;
      rs2E       <= '0;
      rdE        <= '0;
      aluOpE     <= rvPkg::opAdd;
      aluSrcE    <= 1'b0;
      brCondE    <= rvPkg::brEq;
    end else begin
      regWriteE  <= regWriteD & ~bubbleD;  // Bubble kills all side effects
      memWriteE  <= memWriteD & ~bubbleD;
      branchE    <= branchD & ~bubbleD;
      jumpE      <= jumpD & ~bubbleD;
      resultSrcE <= bubbleD ? rvPkg::srcAlu : resultSrcD;
      rd1E       <= rd1D;
      rd2E       <= rd2D;
      immExtE    <= immExtD;
      pcE        <= pcD;
      rs1E       <= rs1D;
      rs2E       <= rs2D;
      rdE        <= rdD;
      aluOpE     <= aluOpD;
      aluSrcE    <= aluSrcD;
      brCondE    <= brCondD;
    end
  end

  always_comb begin
    srcAE      = fwdMux(forwardAE, rd1E);
    writeDataE = fwdMux(forwardBE, rd2E);  // Store data is forwarded rs2
    srcBE      = aluSrcE ? immExtE : writeDataE;
  end

  alu alu0 (
    .a        (srcAE),
    .b        (srcBE),
    .aluOp    (aluOpE),
    .result   (aluResultE),
    .zero     (zeroE),
    .lessThan (lessE)
  );

  always_comb begin
    unique case (brCondE)
      rvPkg::brEq: condMetE = zeroE;
      rvPkg::brNe: condMetE = ~zeroE;
      rvPkg::brLt: condMetE = lessE;
      default:     condMetE = ~lessE;  // bge
    endcase
  end

  assign pcSrcE    = (branchE & condMetE) | jumpE;
  assign pcTargetE = pcE + immExtE;        // PC-relative for branch and jal
  assign pcPlus4E  = pcE + `XLEN'(4);      // Link value

endmodule

//--- stageM.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module stageM (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic [`XLEN-1:0]       aluResultE,
  input  logic [`XLEN-1:0]       writeDataE,
  input  logic [`REG_ADDR_W-1:0] rdE,
  input  logic                   regWriteE,
  input  rvPkg::resultSrcT       resultSrcE,
  input  logic                   memWriteE,
  input  logic [`XLEN-1:0]       pcPlus4E,
  output logic [`XLEN-1:0]       aluResultM,  // Also the load and store address
  output logic [`REG_ADDR_W-1:0] rdM,
  output logic                   regWriteM,
  output rvPkg::resultSrcT       resultSrcM,
  output logic [`XLEN-1:0]       resultW,
  output logic [`REG_ADDR_W-1:0] rdW,
  output logic                   regWriteW
);

  localparam int AddrW = $clog2(`DMEM_WORDS);

  logic [`XLEN-1:0] writeDataM;
  logic             memWriteM;
  logic [`XLEN-1:0] pcPlus4M;
  logic [AddrW-1:0] wordAddrM;
  logic [`XLEN-1:0] readDataM;
  logic [`XLEN-1:0] resultM;
  logic [`XLEN-1:0] dmem [`DMEM_WORDS];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regWriteM  <= 1'b0;
      memWriteM  <= 1'b0;
      resultSrcM <= rvPkg::srcAlu;
      aluResultM <= '0;
      writeDataM <= '0;
      rdM        <= '0;
      pcPlus4M   <= '0;
    end else begin
      regWriteM  <= regWriteE;
      memWriteM  <= memWriteE;
      resultSrcM <= resultSrcE;
      aluResultM <= aluResultE;
      writeDataM <= writeDataE;
      rdM        <= rdE;
      pcPlus4M   <= pcPlus4E;
    end
  end

  assign wordAddrM = aluResultM[AddrW+1:2];   // Word addressed, low bits ignored
  assign readDataM = dmem[wordAddrM];         // Async read

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (memWriteM) begin
      dmem[wordAddrM] <= writeDataM;          // Visible to a load next cycle
    end
  end

  always_comb begin
    unique case (resultSrcM)
      rvPkg::srcMem: resultM = readDataM;
      rvPkg::srcPc4: resultM = pcPlus4M;
      default:       resultM = aluResultM;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      regWriteW <= 1'b0;
      rdW       <= '0;
      resultW   <= '0;
    end else begin
      regWriteW <= regWriteM;
      rdW       <= rdM;
      resultW   <= resultM;
    end
  end

endmodule

//--- tbCore.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module tbCore;

  localparam int NumInstr = 400;         // Random instructions per run
  localparam int MaxHold  = 4;           // Longest legal stall hold
  localparam int MaxDrain = 20;          // Cycles allowed to empty the pipe

  logic                   clk;
  logic                   arstN;
  logic                   validD;
  logic [`REG_ADDR_W-1:0] rs1D;
  logic [`REG_ADDR_W-1:0] rs2D;
  logic [`REG_ADDR_W-1:0] rdD;
  logic [`XLEN-1:0]       immExtD;
  logic [`XLEN-1:0]       pcD;
  rvPkg::aluOpT           aluOpD;
  logic                   aluSrcD;
  logic                   regWriteD;
  logic                   memWriteD;
  rvPkg::resultSrcT       resultSrcD;
  logic                   branchD;
  rvPkg::brCondT          brCondD;
  logic                   jumpD;
  logic                   stallD;
  logic                   pcSrcE;
  logic [`XLEN-1:0]       pcTargetE;
  logic                   regWriteW;
  logic [`REG_ADDR_W-1:0] rdW;
  logic [`XLEN-1:0]       resultW;
  int                     errCount;
  int                     checkCount;
  logic                   idle;          // Monitor has nothing outstanding

  logic [31:0]            lfsr;
  logic [`XLEN-1:0]       pc;
  logic                   lastStall;     // stallD seen at the last rising edge
  logic                   timedOut;
  int                     issued;
  int                     waitCount;

  always #5 clk = ~clk;

  always @(posedge clk) lastStall <= stallD;

  rvExecuteCore dut0 (
    .clk, .arstN, .validD, .rs1D, .rs2D, .rdD, .immExtD, .pcD,
    .aluOpD, .aluSrcD, .regWriteD, .memWriteD, .resultSrcD,
    .branchD, .brCondD, .jumpD,
    .stallD, .pcSrcE, .pcTargetE, .regWriteW, .rdW, .resultW
  );

  tbMonitor mon0 (
    .clk, .arstN, .validD, .rs1D, .rs2D, .rdD, .immExtD, .pcD,
    .aluOpD, .aluSrcD, .regWriteD, .memWriteD, .resultSrcD,
    .branchD, .brCondD, .jumpD,
    .stallD, .pcSrcE, .pcTargetE, .regWriteW, .rdW, .resultW,
    .errCount, .checkCount, .idle
  );

  // Galois form, right shift, taps 32 22 2 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
    return val;
  endfunction

  // x0..x3 only, keeps dependencies dense
  function automatic logic [`REG_ADDR_W-1:0] pickReg();
    logic [31:0] r;
    r = takeBits(2);
    return r[`REG_ADDR_W-1:0];
  endfunction

  function automatic logic [`XLEN-1:0] pickImm12();
    logic [31:0] r;
    r = takeBits(12);
    return {{(`XLEN-12){r[11]}}, r[11:0]};  // Sign extended
  endfunction

  task automatic clearSlot();
    validD     = 1'b0;
    rs1D       = '0;
    rs2D       = '0;
    rdD        = '0;
    immExtD    = '0;
    pcD        = '0;
    aluOpD     = rvPkg::opAdd;
    aluSrcD    = 1'b0;
    regWriteD  = 1'b0;
    memWriteD  = 1'b0;
    resultSrcD = rvPkg::srcAlu;
    branchD    = 1'b0;
    brCondD    = rvPkg::brEq;
    jumpD      = 1'b0;
  endtask

  // Unused source fields stay x0 so they never match a load rd
  task automatic makeInstr();
    logic [31:0] kind;
    logic [31:0] r;
    clearSlot();
    validD = 1'b1;
    pcD    = pc;
    pc     = pc + `XLEN'(4);
    kind   = takeBits(4);
    if (kind < 5) begin                      // Register-register ALU op
      r         = takeBits(3);
      aluOpD    = rvPkg::aluOpT'(r[2:0]);
      rs1D      = pickReg();
      rs2D      = pickReg();
      rdD       = pickReg();
      regWriteD = 1'b1;
    end else if (kind < 8) begin             // ALU op with immediate
      r         = takeBits(3);
      aluOpD    = rvPkg::aluOpT'(r[2:0]);
      rs1D      = pickReg();
      rdD       = pickReg();
      immExtD   = pickImm12();
      aluSrcD   = 1'b1;
      regWriteD = 1'b1;
    end else if (kind < 10) begin            // Load, base x0, 8 words
      r          = takeBits(3);
      immExtD    = `XLEN'(r[2:0]) << 2;
      rdD        = pickReg();
      aluSrcD    = 1'b1;
      regWriteD  = 1'b1;
      resultSrcD = rvPkg::srcMem;
    end else if (kind < 12) begin            // Store to the same 8 words
      r         = takeBits(3);
      immExtD   = `XLEN'(r[2:0]) << 2;
      rs2D      = pickReg();
      aluSrcD   = 1'b1;
      memWriteD = 1'b1;
    end else if (kind < 14) begin            // Conditional branch
      r       = takeBits(2);
      brCondD = rvPkg::brCondT'(r[1:0]);
      rs1D    = pickReg();
      rs2D    = pickReg();
      immExtD = pickImm12() & ~`XLEN'(1);
      aluOpD  = rvPkg::opSub;
      branchD = 1'b1;
    end else if (kind == 14) begin           // jal
      rdD        = pickReg();
      immExtD    = pickImm12() & ~`XLEN'(1);
      aluSrcD    = 1'b1;
      regWriteD  = 1'b1;
      resultSrcD = rvPkg::srcPc4;
      jumpD      = 1'b1;
    end else begin
      validD = 1'b0;                         // Empty slot
    end
  endtask

  initial begin
    clk       = 1'b0;
    arstN     = 1'b1;
    lfsr      = 32'd83075;
    pc        = '0;
    lastStall = 1'b0;
    timedOut  = 1'b0;
    clearSlot();
    #1 arstN = 1'b0;                         // Clean falling edge for the async reset
    repeat (10) @(posedge clk);
    @(negedge clk);
    arstN     = 1'b1;
    issued    = 0;
    waitCount = 0;
    // Last pass drives an empty slot after the final instruction
    while (issued <= NumInstr && !timedOut) begin
      @(negedge clk);
      if (lastStall) begin
        waitCount++;                         // Hold the same instruction
        if (waitCount > MaxHold) begin
          $display("Timeout: stallD held one instruction for more than %0d cycles", MaxHold);
          timedOut = 1'b1;
        end
      end else begin
        waitCount = 0;
        if (issued < NumInstr) begin
          makeInstr();
        end else begin
          clearSlot();
        end
        issued++;
      end
    end
    waitCount = 0;
    while (!idle && !timedOut) begin
      @(negedge clk);
      waitCount++;
      if (waitCount > MaxDrain) begin
        $display("Timeout: expected results still pending after %0d cycles", MaxDrain);
        timedOut = 1'b1;
      end
    end
    @(negedge clk);
    $display("Checks: %0d, errors: %0d", checkCount, errCount);
    if (timedOut || errCount != 0) begin
      $display("SOME TESTS FAILED");
    end else begin
      $display("ALL TESTS PASSED");
    end
    $finish;
  end

endmodule

//--- tbMonitor.sv
`timescale 1ns/1ps
`include "pipe_config.svh"

module tbMonitor (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   validD,
  input  logic [`REG_ADDR_W-1:0] rs1D,
  input  logic [`REG_ADDR_W-1:0] rs2D,
  input  logic [`REG_ADDR_W-1:0] rdD,
  input  logic [`XLEN-1:0]       immExtD,
  input  logic [`XLEN-1:0]       pcD,
  input  rvPkg::aluOpT           aluOpD,
  input  logic                   aluSrcD,
  input  logic                   regWriteD,
  input  logic                   memWriteD,
  input  rvPkg::resultSrcT       resultSrcD,
  input  logic                   branchD,
  input  rvPkg::brCondT          brCondD,
  input  logic                   jumpD,
  input  logic                   stallD,
  input  logic                   pcSrcE,
  input  logic [`XLEN-1:0]       pcTargetE,
  input  logic                   regWriteW,
  input  logic [`REG_ADDR_W-1:0] rdW,
  input  logic [`XLEN-1:0]       resultW,
  output int                     errCount,
  output int                     checkCount,
  output logic                   idle
);

  localparam int NumRegs = 1 << `REG_ADDR_W;

  logic [`XLEN-1:0]       regs [NumRegs];    // Architectural state
  logic [`XLEN-1:0]       mem [`DMEM_WORDS];
  logic                   wbV [3];           // Slot 2 is due at this edge
  logic                   wbWe [3];
  logic [`REG_ADDR_W-1:0] wbRd [3];
  logic [`XLEN-1:0]       wbVal [3];
  logic                   takenE;            // Redirect due at this edge
  logic [`XLEN-1:0]       targetE;
  logic [`REG_ADDR_W-1:0] loadRdE;           // Load now in execute, or x0
  logic                   expStall;
  logic                   accepted;
  logic                   squashed;
  int                     errors = 0;
  int                     checks = 0;

  assign errCount   = errors;
  assign checkCount = checks;
  assign idle       = !(wbV[0] || wbV[1] || wbV[2] || takenE);

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s got %h exp %h at %0t", name, got, exp, $time);
    end
  endtask

  // RV32I semantics of the eight ops
  function automatic logic [`XLEN-1:0] refAlu(input rvPkg::aluOpT op,
                                               input logic [`XLEN-1:0] a,
                                               input logic [`XLEN-1:0] b);
    logic [`XLEN-1:0] r;
    case (op)
      rvPkg::opAdd: r = a + b;
      rvPkg::opSub: r = a - b;
      rvPkg::opAnd: r = a & b;
      rvPkg::opOr:  r = a | b;
      rvPkg::opXor: r = a ^ b;
      rvPkg::opSlt: r = ($signed(a) < $signed(b)) ? `XLEN'(1) : '0;
      rvPkg::opSll: r = a << b[4:0];
      default:      r = a >> b[4:0];         // srl
    endcase
    return r;
  endfunction

  function automatic logic condHolds(input rvPkg::brCondT cond,
                                     input logic [`XLEN-1:0] a,
                                     input logic [`XLEN-1:0] b);
    logic hit;
    case (cond)
      rvPkg::brEq: hit = (a == b);
      rvPkg::brNe: hit = (a != b);
      rvPkg::brLt: hit = ($signed(a) < $signed(b));
      default:     hit = ($signed(a) >= $signed(b));
    endcase
    return hit;
  endfunction

  // Executes the decode slot in program order
  task automatic modelStep();
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] storeVal;
    logic [`XLEN-1:0] aluVal;
    logic [`XLEN-1:0] wbValue;
    int               wordIdx;
    opA      = regs[rs1D];
    storeVal = regs[rs2D];
    opB      = aluSrcD ? immExtD : storeVal;
    aluVal   = refAlu(aluOpD, opA, opB);
    wordIdx  = int'((aluVal >> 2) % `DMEM_WORDS);  // Byte address to word
    case (resultSrcD)
      rvPkg::srcMem: wbValue = mem[wordIdx];
      rvPkg::srcPc4: wbValue = pcD + `XLEN'(4);
      default:       wbValue = aluVal;
    endcase
    if (memWriteD) begin
      mem[wordIdx] = storeVal;
    end
    takenE   = (branchD && condHolds(brCondD, opA, storeVal)) || jumpD;
    targetE  = pcD + immExtD;
    loadRdE  = (regWriteD && resultSrcD == rvPkg::srcMem) ? rdD : '0;
    wbV[0]   = 1'b1;
    wbWe[0]  = regWriteD;
    wbRd[0]  = rdD;
    wbVal[0] = wbValue;
    if (regWriteD && rdD != '0) begin
      regs[rdD] = wbValue;                   // x0 stays zero
    end
  endtask

  // Samples just before the edge, when every DUT signal is settled
  always @(posedge clk) begin
    if (!arstN) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] = '0;
      end
      for (int i = 0; i < `DMEM_WORDS; i++) begin
        mem[i] = '0;
      end
      for (int k = 0; k < 3; k++) begin
        wbV[k]   = 1'b0;
        wbWe[k]  = 1'b0;
        wbRd[k]  = '0;
        wbVal[k] = '0;
      end
      takenE  = 1'b0;
      targetE = '0;
      loadRdE = '0;
    end else begin
      expStall = validD && (loadRdE != '0) && ((rs1D == loadRdE) || (rs2D == loadRdE));
      compare("stallD", 32'(stallD), 32'(expStall));
      compare("pcSrcE", 32'(pcSrcE), 32'(takenE));
      if (takenE) begin
        compare("pcTargetE", pcTargetE, targetE);
      end
      compare("regWriteW", 32'(regWriteW), 32'(wbV[2] && wbWe[2]));
      if (wbV[2] && wbWe[2]) begin
        compare("rdW", 32'(rdW), 32'(wbRd[2]));
        compare("resultW", resultW, wbVal[2]);
      end
      for (int k = 2; k > 0; k--) begin      // Age the expected writebacks
        wbV[k]   = wbV[k-1];
        wbWe[k]  = wbWe[k-1];
        wbRd[k]  = wbRd[k-1];
        wbVal[k] = wbVal[k-1];
      end
      accepted = validD && !stallD;
      squashed = accepted && takenE;         // Slot after a taken branch
      wbV[0]   = 1'b0;
      wbWe[0]  = 1'b0;
      takenE   = 1'b0;
      loadRdE  = '0;
      if (accepted && !squashed) begin
        modelStep();
      end
    end
  end

endmodule
